// File: common/pong_pkg.sv
package pong_pkg;

    localparam int coord_w = 10;
    localparam int speed_w = 8;

    localparam logic [coord_w-1:0] x_step = 10'd12;   // pixels per step.
    localparam int gravity_steps = 6;                 // steps between vy increments.

    // launch values.
    localparam logic [coord_w-1:0] start_x  = 10'd100;
    localparam logic [coord_w-1:0] start_y  = 10'd80;
    localparam logic signed [7:0]  start_vy = -8'sd3;

    // field limits, the second of each pair applies when upscale is set.
    localparam logic [coord_w-1:0] y_max_base   = 10'd239;
    localparam logic [coord_w-1:0] y_max_up     = 10'd479;
    localparam logic [coord_w-1:0] x_right_base = 10'd300;
    localparam logic [coord_w-1:0] x_right_up   = 10'd620;

    typedef struct packed {
        logic [coord_w-1:0] x;
        logic [coord_w-1:0] y;
        logic signed [7:0]  vy;
        logic [2:0]         phase;   // gravity phase, 0 to 5.
        logic               left;    // moving toward the miss edge.
    } ball_t;

    // ball state handed to the other board.
    typedef struct packed {
        logic [coord_w-1:0] y;
        logic [7:0]         vy;
        logic [2:0]         phase;
        logic [speed_w-1:0] speed;
    } ball_msg_t;

    typedef struct packed {
        logic               valid;
        logic [speed_w-1:0] speed;   // already clamped to 1..255.
    } hit_t;

    typedef enum logic [1:0] {
        idle   = 2'd0,
        run    = 2'd1,
        missed = 2'd2,
        away   = 2'd3
    } game_state_e;

    localparam ball_t start_ball = '{
        x:     start_x,
        y:     start_y,
        vy:    start_vy,
        phase: 3'd0,
        left:  1'b1
    };

endpackage

// File: source/hit_capture.sv
`timescale 1ns/1ps

module hit_capture (
    input  logic            clk_25MHZ,
    input  logic            reset,
    input  logic            collision_detected,
    input  logic [9:0]      estimated_speed,
    output pong_pkg::hit_t  hit
);
    import pong_pkg::*;

    logic               collision_q;
    logic               hit_valid_q;
    logic [speed_w-1:0] hit_speed_q;
    logic [speed_w-1:0] clamped;

    // slow swings still move the ball.
    always_comb begin
        if (estimated_speed < 10'd2) begin
            clamped = speed_w'(1);
        end else if (estimated_speed[9:speed_w] != '0) begin
            clamped = '1;                               // saturate at 255.
        end else begin
            clamped = estimated_speed[speed_w-1:0];
        end
    end

    always_ff @(posedge clk_25MHZ or posedge reset) begin
        if (reset) begin
            collision_q <= 1'b0;
            hit_valid_q <= 1'b0;
        end else begin
            collision_q <= collision_detected;
            hit_valid_q <= collision_detected && !collision_q;   // rising edge only.
        end
    end

    always_ff @(posedge clk_25MHZ) begin
        hit_speed_q <= clamped;
    end

    assign hit = '{valid: hit_valid_q, speed: hit_speed_q};

endmodule

// File: ball/step_timer.sv
`timescale 1ns/1ps

module step_timer #(
    parameter int base_period = 270000
) (
    input  logic       clk_25MHZ,
    input  logic       reset,
    input  logic [7:0] speed,
    input  logic       restart,
    output logic       step
);
    import pong_pkg::*;

    localparam int cnt_w = $clog2(base_period + 1);

    logic [speed_w-1:0] speed_q;
    logic [speed_w-1:0] divisor;
    logic [31:0]        quotient;
    logic [cnt_w-1:0]   period_q;
    logic [cnt_w-1:0]   count_q;

    assign divisor  = (speed == '0) ? speed_w'(1) : speed;
    assign quotient = 32'(base_period) / 32'(divisor);

    // restart holds the count at zero, so the first step lands one period later.
    assign step = !restart && (count_q >= period_q - 1'b1);

    always_ff @(posedge clk_25MHZ or posedge reset) begin
        if (reset) begin
            speed_q  <= speed_w'(1);
            period_q <= cnt_w'(base_period);
            count_q  <= '0;
        end else begin
            if (speed != speed_q) begin
                speed_q  <= speed;
                // fast hits on a short base period still need one cycle.
                period_q <= (quotient == 32'd0) ? cnt_w'(1) : cnt_w'(quotient);
            end
            if (restart || step) begin
                count_q <= '0;
            end else begin
                count_q <= count_q + 1'b1;
            end
        end
    end

endmodule

// File: ball/ball_motion.sv
`timescale 1ns/1ps

module ball_motion (
    input  logic                  clk_25MHZ,
    input  logic                  reset,
    input  logic                  upscale,
    input  logic                  game_start,
    input  pong_pkg::hit_t        hit,
    input  logic                  step,
    input  logic                  arrive,
    input  pong_pkg::ball_msg_t   arrive_msg,
    output logic [7:0]            speed,
    output logic                  restart,
    output pong_pkg::ball_t       ball,
    output pong_pkg::game_state_e state,
    output logic                  send,
    output pong_pkg::ball_msg_t   send_msg
);
    import pong_pkg::*;

    game_state_e        state_q;
    game_state_e        state_n;
    ball_t              ball_q;
    ball_t              ball_n;
    ball_t              stepped;
    logic [speed_w-1:0] speed_q;
    logic [speed_w-1:0] speed_n;
    logic               restart_q;
    logic               restart_n;
    logic               send_q;
    logic               send_n;
    logic [coord_w-1:0] y_max;
    logic [coord_w-1:0] x_right;

    // one step of motion, gravity and wall bounce.
    function automatic ball_t step_ball(input ball_t b,
                                        input logic [coord_w-1:0] top,
                                        input logic [coord_w-1:0] right);
        ball_t                     n;
        logic signed [coord_w+1:0] y_sum;
        logic signed [coord_w+1:0] y_top;

        n     = b;
        y_top = $signed({2'b00, top});
        y_sum = $signed({2'b00, b.y}) + $signed({{4{b.vy[7]}}, b.vy});   // uses the old vy.

        if (b.phase == 3'(gravity_steps - 1)) begin
            n.vy    = b.vy + 8'sd1;
            n.phase = 3'd0;
        end else begin
            n.phase = b.phase + 3'd1;
        end

        if (y_sum >= y_top) begin
            n.y  = top;
            n.vy = -n.vy;
        end else if (y_sum <= 0) begin
            n.y  = '0;
            n.vy = -n.vy;
        end else begin
            n.y = y_sum[coord_w-1:0];
        end

        // x stops at the edge it reaches.
        if (b.left) begin
            n.x = (b.x <= x_step) ? '0 : b.x - x_step;
        end else begin
            n.x = (b.x + x_step >= right) ? right : b.x + x_step;
        end
        return n;
    endfunction

    assign y_max   = upscale ? y_max_up : y_max_base;
    assign x_right = upscale ? x_right_up : x_right_base;
    assign stepped = step_ball(ball_q, y_max, x_right);

    always_comb begin
        state_n   = state_q;
        ball_n    = ball_q;
        speed_n   = speed_q;
        restart_n = 1'b0;
        send_n    = 1'b0;

        case (state_q)
            idle, missed: begin
                if (game_start) begin
                    state_n   = run;
                    ball_n    = start_ball;
                    speed_n   = speed_w'(1);
                    restart_n = 1'b1;
                end
            end

            run: begin
                if (hit.valid && ball_q.left) begin   // a hit beats a step in the same cycle.
                    ball_n.left = 1'b0;
                    speed_n     = hit.speed;
                    restart_n   = 1'b1;
                end else if (step) begin
                    ball_n = stepped;
                    if (ball_q.left && stepped.x == '0) begin
                        state_n = missed;
                    end else if (!ball_q.left && stepped.x >= x_right) begin
                        state_n = away;
                        send_n  = 1'b1;
                    end
                end
            end

            away: begin
                if (arrive) begin
                    state_n      = run;
                    ball_n.x     = x_right;   // comes back in at the hand-off edge.
                    ball_n.y     = arrive_msg.y;
                    ball_n.vy    = arrive_msg.vy;
                    ball_n.phase = arrive_msg.phase;
                    ball_n.left  = 1'b1;
                    speed_n      = arrive_msg.speed;
                    restart_n    = 1'b1;
                end
            end

            default: state_n = idle;
        endcase
    end

    always_ff @(posedge clk_25MHZ or posedge reset) begin
        if (reset) begin
            state_q   <= idle;
            ball_q    <= start_ball;
            speed_q   <= speed_w'(1);
            restart_q <= 1'b0;
            send_q    <= 1'b0;
        end else begin
            state_q   <= state_n;
            ball_q    <= ball_n;
            speed_q   <= speed_n;
            restart_q <= restart_n;
            send_q    <= send_n;
        end
    end

    assign speed    = speed_q;
    assign restart  = restart_q;
    assign ball     = ball_q;
    assign state    = state_q;
    assign send     = send_q;
    assign send_msg = '{y: ball_q.y, vy: ball_q.vy, phase: ball_q.phase, speed: speed_q};

endmodule

// File: source/ball_link.sv
`timescale 1ns/1ps

module ball_link (
    input  logic                  clk_25MHZ,
    input  logic                  reset,
    input  pong_pkg::game_state_e state,
    input  logic                  send,
    input  pong_pkg::ball_msg_t   send_msg,
    output logic                  tx_valid,
    input  logic                  tx_ready,
    output pong_pkg::ball_msg_t   tx_msg,
    input  logic                  rx_valid,
    output logic                  rx_ready,
    input  pong_pkg::ball_msg_t   rx_msg,
    output logic                  arrive,
    output pong_pkg::ball_msg_t   arrive_msg,
    output logic                  game_over
);
    import pong_pkg::*;

    always_ff @(posedge clk_25MHZ or posedge reset) begin
        if (reset) begin
            tx_valid  <= 1'b0;
            game_over <= 1'b0;
        end else begin
            if (send) begin
                tx_valid <= 1'b1;
            end else if (tx_ready) begin
                tx_valid <= 1'b0;                  // accepted.
            end
            game_over <= (state == missed);
        end
    end

    // loaded once per hand-off, steady until accepted.
    always_ff @(posedge clk_25MHZ) begin
        if (send) begin
            tx_msg <= send_msg;
        end
    end

    // the ball can only come back after ours has left.
    assign rx_ready   = (state == away) && !tx_valid && !send;
    assign arrive     = rx_valid && rx_ready;
    assign arrive_msg = rx_msg;

endmodule

// File: source/pong_table_top.sv
`timescale 1ns/1ps

module pong_table_top #(
    parameter int base_period = 270000
) (
    input  logic                clk_25MHZ,
    input  logic                reset,
    input  logic                upscale,
    input  logic                game_start,
    input  logic                collision_detected,
    input  logic [9:0]          estimated_speed,
    output logic [9:0]          ball_x,
    output logic [9:0]          ball_y,
    output logic                moving_left,
    output logic                game_over,
    output logic                tx_valid,
    input  logic                tx_ready,
    output pong_pkg::ball_msg_t tx_msg,
    input  logic                rx_valid,
    output logic                rx_ready,
    input  pong_pkg::ball_msg_t rx_msg
);
    import pong_pkg::*;

    hit_t               hit;
    logic [speed_w-1:0] speed;
    logic               restart;
    logic               step;
    ball_t              ball;
    game_state_e        state;
    logic               send;
    ball_msg_t          send_msg;
    logic               arrive;
    ball_msg_t          arrive_msg;

    hit_capture hit_capture_inst (
        .clk_25MHZ          (clk_25MHZ),
        .reset              (reset),
        .collision_detected (collision_detected),
        .estimated_speed    (estimated_speed),
        .hit                (hit)
    );

    step_timer #(
        .base_period (base_period)
    ) step_timer_inst (
        .clk_25MHZ (clk_25MHZ),
        .reset     (reset),
        .speed     (speed),
        .restart   (restart),
        .step      (step)
    );

    ball_motion ball_motion_inst (
        .clk_25MHZ  (clk_25MHZ),
        .reset      (reset),
        .upscale    (upscale),
        .game_start (game_start),
        .hit        (hit),
        .step       (step),
        .arrive     (arrive),
        .arrive_msg (arrive_msg),
        .speed      (speed),
        .restart    (restart),
        .ball       (ball),
        .state      (state),
        .send       (send),
        .send_msg   (send_msg)
    );

    ball_link ball_link_inst (
        .clk_25MHZ  (clk_25MHZ),
        .reset      (reset),
        .state      (state),
        .send       (send),
        .send_msg   (send_msg),
        .tx_valid   (tx_valid),
        .tx_ready   (tx_ready),
        .tx_msg     (tx_msg),
        .rx_valid   (rx_valid),
        .rx_ready   (rx_ready),
        .rx_msg     (rx_msg),
        .arrive     (arrive),
        .arrive_msg (arrive_msg),
        .game_over  (game_over)
    );

    assign ball_x      = ball.x;
    assign ball_y      = ball.y;
    assign moving_left = ball.left;

endmodule

// File: sim/pong_table_checker.sv
`timescale 1ns/1ps

module pong_table_checker (
    input logic                clk_25MHZ,
    input logic                reset,
    input logic                tx_valid,
    input logic                tx_ready,
    input pong_pkg::ball_msg_t tx_msg,
    input logic                rx_ready,
    input logic                game_over
);

    int failures = 0;

    // a stalled message must not move.
    tx_msg_held: assert property (
        @(posedge clk_25MHZ) disable iff (reset)
        tx_valid && !tx_ready |=> $stable(tx_msg)
    ) else begin
        $error("tx_msg changed while tx_valid waited for tx_ready");
        failures++;
    end

    // the ball may only come back once ours was taken.
    link_one_way: assert property (
        @(posedge clk_25MHZ) disable iff (reset)
        $rose(rx_ready) |-> $past(tx_valid && tx_ready)
    ) else begin
        $error("rx_ready opened before the outgoing ball was accepted");
        failures++;
    end

    // a fresh table starts idle, never in a missed game.
    quiet_after_reset: assert property (
        @(posedge clk_25MHZ)
        $fell(reset) |-> !game_over [*3]
    ) else begin
        $error("game_over went high right after reset");
        failures++;
    end

endmodule

bind ball_link pong_table_checker checker_inst (
    .clk_25MHZ (clk_25MHZ),
    .reset     (reset),
    .tx_valid  (tx_valid),
    .tx_ready  (tx_ready),
    .tx_msg    (tx_msg),
    .rx_ready  (rx_ready),
    .game_over (game_over)
);

// File: sim/pong_table_tb.sv
`timescale 1ns/1ps

module pong_table_tb;
    import pong_pkg::*;

    localparam int tb_base_period = 60;
    localparam int rounds         = 3;
    localparam int max_pass_steps = int'(x_right_up) / int'(x_step) + 2;
    // launch, outgoing and returning pass per round, each at most one field wide.
    localparam int timeout_cycles =
        2 * rounds * (3 * max_pass_steps * (tb_base_period + 1) + 64);

    logic       clk_25MHZ;
    logic       reset;
    logic       upscale;
    logic       game_start;
    logic       collision_detected;
    logic [9:0] estimated_speed;
    logic [9:0] ball_x;
    logic [9:0] ball_y;
    logic       moving_left;
    logic       game_over;
    logic       tx_valid;
    logic       tx_ready;
    ball_msg_t  tx_msg;
    logic       rx_valid;
    logic       rx_ready;
    ball_msg_t  rx_msg;

    ball_t       model;
    logic [7:0]  model_speed;
    logic        load_pending;
    logic        armed;             // gap check valid for the next step.
    logic [9:0]  last_x;
    logic [31:0] lfsr_state;
    logic [9:0]  est;
    int          steps_seen;
    int          gap;
    int          cycle_count = 0;
    int          top_seen[2];
    int          bottom_seen[2];

    pong_table_top #(
        .base_period (tb_base_period)
    ) pong_table_top_inst (
        .clk_25MHZ          (clk_25MHZ),
        .reset              (reset),
        .upscale            (upscale),
        .game_start         (game_start),
        .collision_detected (collision_detected),
        .estimated_speed    (estimated_speed),
        .ball_x             (ball_x),
        .ball_y             (ball_y),
        .moving_left        (moving_left),
        .game_over          (game_over),
        .tx_valid           (tx_valid),
        .tx_ready           (tx_ready),
        .tx_msg             (tx_msg),
        .rx_valid           (rx_valid),
        .rx_ready           (rx_ready),
        .rx_msg             (rx_msg)
    );

    initial begin
        clk_25MHZ = 1'b0;
        forever #20 clk_25MHZ = ~clk_25MHZ;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // taps 32, 22, 2, 1.
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v          = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [7:0] clamp_speed(input logic [9:0] e);
        if (e < 10'd2) return 8'd1;
        if (e > 10'd255) return 8'd255;
        return e[7:0];
    endfunction

    function automatic int step_period(input logic [7:0] s);
        int p;
        p = tb_base_period / int'(s);
        return (p < 1) ? 1 : p;
    endfunction

    // expected ball after one step.
    function automatic ball_t ref_step(input ball_t b, input logic up);
        ball_t n;
        int    nx;
        int    ny;
        int    nvy;
        int    top;
        int    right;
        top   = up ? int'(y_max_up) : int'(y_max_base);
        right = up ? int'(x_right_up) : int'(x_right_base);
        nvy   = int'(b.vy);
        nx    = b.left ? int'(b.x) - int'(x_step) : int'(b.x) + int'(x_step);
        if (nx <= 0) nx = 0;
        if (nx >= right) nx = right;
        ny = int'(b.y) + nvy;                           // old vy.
        if (b.phase == 3'(gravity_steps - 1)) begin
            nvy     = nvy + 1;
            n.phase = 3'd0;
        end else begin
            n.phase = b.phase + 3'd1;
        end
        if (ny >= top) begin
            ny  = top;
            nvy = -nvy;
        end else if (ny <= 0) begin
            ny  = 0;
            nvy = -nvy;
        end
        n.x    = nx[9:0];
        n.y    = ny[9:0];
        n.vy   = nvy[7:0];
        n.left = b.left;
        return n;
    endfunction

    function automatic ball_t current_ball();
        ball_t b;
        b.x     = ball_x;
        b.y     = ball_y;
        b.vy    = pong_table_top_inst.ball.vy;
        b.phase = pong_table_top_inst.ball.phase;
        b.left  = moving_left;
        return b;
    endfunction

    function automatic string ball_text(input ball_t b);
        return $sformatf("x=%0d y=%0d vy=%0d ph=%0d l=%0b",
                         b.x, b.y, b.vy, b.phase, b.left);
    endfunction

    function automatic string msg_text(input ball_msg_t m);
        return $sformatf("y=%0d vy=%0d ph=%0d spd=%0d",
                         m.y, $signed(m.vy), m.phase, m.speed);
    endfunction

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("RESULT: FAIL");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_ball(input ball_t got, input ball_t exp, input string what);
        if (got !== exp) begin
            stop_run($sformatf("CHECK FAILED at %0t ns: %s got %s, exp %s",
                               $time, what, ball_text(got), ball_text(exp)));
        end
    endtask

    task automatic check_msg(input ball_msg_t got, input ball_msg_t exp, input string what);
        if (got !== exp) begin
            stop_run($sformatf("CHECK FAILED at %0t ns: %s got %s, exp %s",
                               $time, what, msg_text(got), msg_text(exp)));
        end
    endtask

    task automatic expect_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            stop_run($sformatf("CHECK FAILED at %0t ns: %s got %b, expected %b",
                               $time, what, got, exp));
        end
    endtask

    task automatic expect_cycles(input int got, input int exp, input string what);
        if (got != exp) begin
            stop_run($sformatf("CHECK FAILED at %0t ns: %s got %0d, expected %0d",
                               $time, what, got, exp));
        end
    endtask

    // compare process, outputs read before this edge updates them.
    always @(posedge clk_25MHZ) begin
        ball_t expected;
        if (reset) begin
            last_x = start_x;
            gap    = 0;
        end else begin
            gap = gap + 1;
            if (ball_x != last_x) begin
                if (load_pending) begin
                    expected     = model;
                    load_pending = 1'b0;
                    armed        = 1'b0;
                end else begin
                    expected = ref_step(model, upscale);
                    if (armed) expect_cycles(gap, step_period(model_speed), "step spacing");
                    armed = 1'b1;
                    steps_seen++;
                    if (expected.y == 10'd0) bottom_seen[upscale]++;
                    if (expected.y == (upscale ? y_max_up : y_max_base)) top_seen[upscale]++;
                end
                check_ball(current_ball(), expected, "ball after x change");
                model  = expected;
                last_x = ball_x;
                gap    = 0;
            end
        end
    end

    always @(negedge clk_25MHZ) begin
        if (pong_table_top_inst.ball_link_inst.checker_inst.failures != 0) begin
            stop_run("a link or game_over assertion failed in the bound checker");
        end
    end

    always @(posedge clk_25MHZ) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
            $display("RESULT: FAIL");
            $fatal(1, "simulation timed out");
        end
    end

    task automatic wait_steps(input int n);
        int target;
        target = steps_seen + n;
        while (steps_seen < target) @(negedge clk_25MHZ);
    endtask

    task automatic launch(input logic up, input logic from_miss);
        upscale      = up;
        load_pending = from_miss;   // only a relaunch moves x.
        model        = start_ball;
        model_speed  = 8'd1;
        armed        = 1'b0;
        game_start   = 1'b1;
        @(negedge clk_25MHZ);
        game_start = 1'b0;
        expect_flag(game_over, from_miss, "game_over one cycle after game_start");
        @(negedge clk_25MHZ);
        expect_flag(game_over, 1'b0, "game_over after launch");
    endtask

    task automatic apply_hit(input logic [9:0] e);
        estimated_speed    = e;
        collision_detected = 1'b1;
        model.left         = 1'b0;
        model_speed        = clamp_speed(e);
        armed              = 1'b0;
        repeat (2) @(negedge clk_25MHZ);   // edge detect, then the FSM.
        collision_detected = 1'b0;
        check_ball(current_ball(), model, "ball after hit");
    endtask

    task automatic hand_off();
        ball_msg_t expected;
        int        delay;
        while (!tx_valid) @(negedge clk_25MHZ);
        expected = '{y: model.y, vy: model.vy, phase: model.phase, speed: model_speed};
        delay    = int'(rand_bits(3));
        repeat (delay) begin
            check_msg(tx_msg, expected, "tx_msg under back-pressure");
            expect_flag(rx_ready, 1'b0, "rx_ready before tx accepted");
            @(negedge clk_25MHZ);
        end
        check_msg(tx_msg, expected, "tx_msg at acceptance");
        expect_flag(tx_valid, 1'b1, "tx_valid held until tx_ready");
        tx_ready = 1'b1;
        @(negedge clk_25MHZ);
        tx_ready = 1'b0;
        expect_flag(tx_valid, 1'b0, "tx_valid after acceptance");
        expect_flag(rx_ready, 1'b1, "rx_ready while away");
    endtask

    task automatic send_return(input logic up);
        ball_msg_t  msg;
        logic [9:0] top;
        top       = up ? y_max_up : y_max_base;
        msg.y     = top - 10'(rand_bits(3));   // near the top, with a steep fall.
        msg.vy    = 8'd20 + 8'(rand_bits(3));
        msg.phase = 3'(rand_bits(2));
        msg.speed = 8'd1 + 8'(rand_bits(2));
        rx_msg    = msg;
        rx_valid  = 1'b1;
        model     = '{x: (up ? x_right_up : x_right_base), y: msg.y, vy: msg.vy,
                      phase: msg.phase, left: 1'b1};
        model_speed = msg.speed;
        armed       = 1'b0;
        @(negedge clk_25MHZ);
        rx_valid = 1'b0;
        check_ball(current_ball(), model, "ball after arrival");
        expect_flag(rx_ready, 1'b0, "rx_ready after arrival");
    endtask

    task automatic await_miss();
        while (!game_over) @(negedge clk_25MHZ);
        expect_cycles(int'(ball_x), 0, "ball_x at the miss");
        repeat (3) begin
            @(negedge clk_25MHZ);
            expect_flag(game_over, 1'b1, "game_over held while missed");
        end
    endtask

    initial begin
        reset              = 1'b1;
        upscale            = 1'b0;
        game_start         = 1'b0;
        collision_detected = 1'b0;
        estimated_speed    = '0;
        tx_ready           = 1'b0;
        rx_valid           = 1'b0;
        rx_msg             = '0;
        model              = start_ball;
        model_speed        = 8'd1;
        load_pending       = 1'b0;
        armed              = 1'b0;
        lfsr_state         = 32'h2e4d;
        steps_seen         = 0;
        top_seen           = '{0, 0};
        bottom_seen        = '{0, 0};
        repeat (3) @(negedge clk_25MHZ);
        reset = 1'b0;
        @(negedge clk_25MHZ);

        for (int r = 0; r < rounds; r++) begin
            launch(r[0], r != 0);
            wait_steps(3);
            case (r)
                0:       est = 10'(rand_bits(1));   // slow swing, speed 1.
                1:       est = 10'(rand_bits(6));
                default: est = 10'(rand_bits(10));
            endcase
            apply_hit(est);
            hand_off();
            send_return(r[0]);
            await_miss();
        end

        if (top_seen[0] == 0 || top_seen[1] == 0 ||
            bottom_seen[0] == 0 || bottom_seen[1] == 0) begin
            stop_run("wall bounces at y = 0 and y_max were not reached for both field sizes");
        end else if (pong_table_top_inst.ball_link_inst.checker_inst.failures != 0) begin
            stop_run("a link or game_over assertion failed in the bound checker");
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule

// File: tb.f
common/pong_pkg.sv
source/hit_capture.sv
ball/step_timer.sv
ball/ball_motion.sv
source/ball_link.sv
source/pong_table_top.sv
sim/pong_table_checker.sv
sim/pong_table_tb.sv

// File: Bender.yml
package:
  name: pong_table

sources:
  - files:
      - common/pong_pkg.sv
      - source/hit_capture.sv
      - ball/step_timer.sv
      - ball/ball_motion.sv
      - source/ball_link.sv
      - source/pong_table_top.sv
  - target: simulation
    files:
      - sim/pong_table_checker.sv
      - sim/pong_table_tb.sv
